//--- src/rename_defines.svh
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// ------------------------------
// register number widths
// ------------------------------
`define LREG_WIDTH      5
`define PREG_WIDTH      6

// logical registers renamed by the stage, inclusive bounds
`define REN_LO          8
`define REN_HI          15

// ------------------------------
// rename table and free list
// ------------------------------
`define MAP_ENTRIES     8
`define MAP_IDX_WIDTH   3

`define FL_DEPTH        16
`define FL_PTR_WIDTH    4
`define FL_RESET_BASE   32
`define FL_RESET_COUNT  8

`endif

//--- src/rename_pkg.sv
`include "rename_defines.svh"

package rename_pkg;

    // ------------------------------
    // register numbers
    // ------------------------------
    typedef logic [`LREG_WIDTH-1:0] lreg_t;
    typedef logic [`PREG_WIDTH-1:0] preg_t;

    // logical register number widened to the operand word
    typedef struct packed {
        logic [`PREG_WIDTH-`LREG_WIDTH-1:0] pad;
        lreg_t                              num;
    } reg_view_t;

    // ------------------------------
    // second source operand
    // ------------------------------
    // one word, read as a register or as an immediate depending on is_imm.
    // the renamed physical register takes the whole word on the way out
    typedef union packed {
        reg_view_t                lreg;
        logic [`PREG_WIDTH-1:0]   imm;
        preg_t                    preg;
    } operand_t;

endpackage

//--- src/alloc_if.sv
`timescale 1ns/1ps

interface alloc_if;
    import rename_pkg::*;

    // two oldest free registers
    preg_t      head_1;
    preg_t      head_2;

    // at least one / at least two free
    logic       avail_1;
    logic       avail_2;

    // registers taken this cycle, 0 to 2
    logic [1:0] pop_count;

    modport ctrl (
        input  head_1,
        input  head_2,
        input  avail_1,
        input  avail_2,
        output pop_count
    );

    modport pool (
        output head_1,
        output head_2,
        output avail_1,
        output avail_2,
        input  pop_count
    );

endinterface

//--- src/map_if.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

interface map_if;
    import rename_pkg::*;

    // ------------------------------
    // read side, six ports
    // ------------------------------
    logic [`MAP_IDX_WIDTH-1:0] src1_idx_1, src2_idx_1, dst_idx_1;
    logic [`MAP_IDX_WIDTH-1:0] src1_idx_2, src2_idx_2, dst_idx_2;
    preg_t                     src1_data_1, src2_data_1, dst_data_1;
    preg_t                     src1_data_2, src2_data_2, dst_data_2;

    // ------------------------------
    // write side, port 2 wins on a clash
    // ------------------------------
    logic                      wr_en_1, wr_en_2;
    logic [`MAP_IDX_WIDTH-1:0] wr_idx_1, wr_idx_2;
    preg_t                     wr_data_1, wr_data_2;

    modport ctrl (
        output src1_idx_1, src2_idx_1, dst_idx_1,
        output src1_idx_2, src2_idx_2, dst_idx_2,
        input  src1_data_1, src2_data_1, dst_data_1,
        input  src1_data_2, src2_data_2, dst_data_2,
        output wr_en_1, wr_idx_1, wr_data_1,
        output wr_en_2, wr_idx_2, wr_data_2
    );

    modport tbl (
        input  src1_idx_1, src2_idx_1, dst_idx_1,
        input  src1_idx_2, src2_idx_2, dst_idx_2,
        output src1_data_1, src2_data_1, dst_data_1,
        output src1_data_2, src2_data_2, dst_data_2,
        input  wr_en_1, wr_idx_1, wr_data_1,
        input  wr_en_2, wr_idx_2, wr_data_2
    );

endinterface

//--- src/free_list.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

module free_list (
    input  logic              clk,
    input  logic              rst_n,
    alloc_if.pool             pool,
    input  logic              push,
    input  rename_pkg::preg_t push_preg
);
    import rename_pkg::*;

    // ------------------------------
    // storage and pointers
    // ------------------------------
    preg_t                    mem [`FL_DEPTH];
    logic [`FL_PTR_WIDTH-1:0] head_ptr;
    logic [`FL_PTR_WIDTH-1:0] tail_ptr;
    logic [`FL_PTR_WIDTH-1:0] head_ptr_plus1;
    logic [`FL_PTR_WIDTH-1:0] pop_ext;
    logic [`FL_PTR_WIDTH:0]   count;
    logic [`FL_PTR_WIDTH:0]   count_nxt;

    // wraps on its own, depth is a power of two
    assign head_ptr_plus1 = head_ptr + 1'b1;

    assign pop_ext = {{(`FL_PTR_WIDTH-2){1'b0}}, pool.pop_count};

    // ------------------------------
    // allocation side
    // ------------------------------
    // two oldest entries, second one only meaningful with avail_2
    assign pool.head_1  = mem[head_ptr];
    assign pool.head_2  = mem[head_ptr_plus1];
    assign pool.avail_1 = (count != '0);
    assign pool.avail_2 = (count > 1);

    // occupancy after this cycle's push and pops
    always_comb begin
        count_nxt = count;
        if (push) begin
            count_nxt = count_nxt + 1'b1;
        end
        count_nxt = count_nxt - {{(`FL_PTR_WIDTH-1){1'b0}}, pool.pop_count};
    end

    // ------------------------------
    // queue contents
    // ------------------------------
    // comes out of reset holding the spare registers in ascending order
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `FL_RESET_COUNT; i++) begin
                mem[i] <= preg_t'(`FL_RESET_BASE + i);
            end
        end else if (push) begin
            mem[tail_ptr] <= push_preg;
        end
    end

    // ------------------------------
    // pointer and count update
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_ptr <= '0;
            tail_ptr <= `FL_PTR_WIDTH'(`FL_RESET_COUNT);
            count    <= (`FL_PTR_WIDTH+1)'(`FL_RESET_COUNT);
        end else begin
            // pops never exceed what avail_1/avail_2 advertise
            head_ptr <= head_ptr + pop_ext;
            if (push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            count <= count_nxt;
        end
    end

endmodule

//--- src/rename_table.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

module rename_table (
    input  logic clk,
    input  logic rst_n,
    map_if.tbl   tbl
);
    import rename_pkg::*;

    // current mapping of logical 8..15, indexed by the low bits
    preg_t map [`MAP_ENTRIES];

    // ------------------------------
    // read ports
    // ------------------------------
    // sources of slot 1
    assign tbl.src1_data_1 = map[tbl.src1_idx_1];
    assign tbl.src2_data_1 = map[tbl.src2_idx_1];

    // sources of slot 2
    assign tbl.src1_data_2 = map[tbl.src1_idx_2];
    assign tbl.src2_data_2 = map[tbl.src2_idx_2];

    // old mappings of the destinations
    assign tbl.dst_data_1 = map[tbl.dst_idx_1];
    assign tbl.dst_data_2 = map[tbl.dst_idx_2];

    // ------------------------------
    // write ports
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // identity map after reset
            for (int i = 0; i < `MAP_ENTRIES; i++) begin
                map[i] <= preg_t'(`REN_LO + i);
            end
        end else begin
            if (tbl.wr_en_1) begin
                map[tbl.wr_idx_1] <= tbl.wr_data_1;
            end
            // younger instruction, so it overrides port 1
            if (tbl.wr_en_2) begin
                map[tbl.wr_idx_2] <= tbl.wr_data_2;
            end
        end
    end

endmodule

//--- src/rename_control.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

module rename_control (
    input  logic                 in_valid_1,
    input  logic                 in_valid_2,
    input  rename_pkg::lreg_t    dst_1,
    input  rename_pkg::lreg_t    dst_2,
    input  rename_pkg::lreg_t    src1_1,
    input  rename_pkg::lreg_t    src1_2,
    input  rename_pkg::operand_t src2_1,
    input  rename_pkg::operand_t src2_2,
    input  logic                 is_imm_1,
    input  logic                 is_imm_2,
    input  logic                 out_ready,
    output logic                 out_valid_1,
    output logic                 out_valid_2,
    output logic                 in_ready,
    output rename_pkg::preg_t    out_dst_1,
    output rename_pkg::preg_t    out_dst_2,
    output rename_pkg::preg_t    out_src1_1,
    output rename_pkg::preg_t    out_src1_2,
    output rename_pkg::operand_t out_src2_1,
    output rename_pkg::operand_t out_src2_2,
    output rename_pkg::preg_t    ppreg_1,
    output rename_pkg::preg_t    ppreg_2,
    alloc_if.ctrl                alloc,
    map_if.ctrl                  map
);
    import rename_pkg::*;

    logic  dst_ren_1, dst_ren_2;
    logic  s1_ren_1, s1_ren_2;
    logic  s2_ren_1, s2_ren_2;
    logic  need_1, need_2;
    logic  enough;
    logic  fire;
    preg_t new_2;

    function automatic logic in_window(input lreg_t r);
        return (r >= `REN_LO) && (r <= `REN_HI);
    endfunction

    // ------------------------------
    // window decode
    // ------------------------------
    assign dst_ren_1 = in_window(dst_1);
    assign dst_ren_2 = in_window(dst_2);
    assign s1_ren_1  = in_window(src1_1);
    assign s1_ren_2  = in_window(src1_2);
    // immediates are never looked up
    assign s2_ren_1  = !is_imm_1 && in_window(src2_1.lreg.num);
    assign s2_ren_2  = !is_imm_2 && in_window(src2_2.lreg.num);

    // table lookups, window is 8..15 so the low bits are the index
    assign map.src1_idx_1 = src1_1[`MAP_IDX_WIDTH-1:0];
    assign map.src2_idx_1 = src2_1.lreg.num[`MAP_IDX_WIDTH-1:0];
    assign map.dst_idx_1  = dst_1[`MAP_IDX_WIDTH-1:0];
    assign map.src1_idx_2 = src1_2[`MAP_IDX_WIDTH-1:0];
    assign map.src2_idx_2 = src2_2.lreg.num[`MAP_IDX_WIDTH-1:0];
    assign map.dst_idx_2  = dst_2[`MAP_IDX_WIDTH-1:0];

    // ------------------------------
    // allocation and handshake
    // ------------------------------
    assign need_1 = in_valid_1 && dst_ren_1;
    assign need_2 = in_valid_2 && dst_ren_2;

    always_comb begin
        case ({need_1, need_2})
            2'b11:          enough = alloc.avail_2;
            2'b10, 2'b01:   enough = alloc.avail_1;
            default:        enough = 1'b1;
        endcase
    end

    assign fire        = in_valid_1 && out_ready && enough;
    assign out_valid_1 = fire;
    assign out_valid_2 = fire && in_valid_2;
    assign in_ready    = fire;

    assign alloc.pop_count = fire ? ({1'b0, need_1} + {1'b0, need_2}) : 2'd0;

    // slot 2 takes the second head only if slot 1 took the first
    assign new_2 = dst_ren_1 ? alloc.head_2 : alloc.head_1;

    assign map.wr_en_1   = fire && need_1;
    assign map.wr_idx_1  = dst_1[`MAP_IDX_WIDTH-1:0];
    assign map.wr_data_1 = alloc.head_1;
    assign map.wr_en_2   = fire && need_2;
    assign map.wr_idx_2  = dst_2[`MAP_IDX_WIDTH-1:0];
    assign map.wr_data_2 = new_2;

    // ------------------------------
    // renamed operands
    // ------------------------------
    assign out_dst_1  = dst_ren_1 ? alloc.head_1 : preg_t'(dst_1);
    assign out_dst_2  = dst_ren_2 ? new_2 : preg_t'(dst_2);
    assign out_src1_1 = s1_ren_1 ? map.src1_data_1 : preg_t'(src1_1);

    always_comb begin
        out_src2_1 = src2_1;
        if (s2_ren_1) begin
            out_src2_1.preg = map.src2_data_1;
        end
    end

    // slot 2 sees slot 1's result ahead of the table
    always_comb begin
        if (src1_2 == dst_1) begin
            out_src1_2 = out_dst_1;
        end else if (s1_ren_2) begin
            out_src1_2 = map.src1_data_2;
        end else begin
            out_src1_2 = preg_t'(src1_2);
        end
    end

    always_comb begin
        out_src2_2 = src2_2;
        if (!is_imm_2 && (src2_2.lreg.num == dst_1)) begin
            out_src2_2.preg = out_dst_1;
        end else if (s2_ren_2) begin
            out_src2_2.preg = map.src2_data_2;
        end
    end

    // previous mapping, slot 2 follows slot 1 on a shared destination
    assign ppreg_1 = map.dst_data_1;
    assign ppreg_2 = (dst_ren_1 && (dst_2 == dst_1)) ? out_dst_1 : map.dst_data_2;

endmodule

//--- src/reg_rename.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

module reg_rename (
    input  logic                 clk,
    input  logic                 rst_n,
    // incoming bundle
    input  logic                 in_valid_1,
    input  logic                 in_valid_2,
    input  rename_pkg::lreg_t    dst_1,
    input  rename_pkg::lreg_t    dst_2,
    input  rename_pkg::lreg_t    src1_1,
    input  rename_pkg::lreg_t    src1_2,
    input  rename_pkg::operand_t src2_1,
    input  rename_pkg::operand_t src2_2,
    input  logic                 is_imm_1,
    input  logic                 is_imm_2,
    output logic                 in_ready,
    // renamed bundle
    input  logic                 out_ready,
    output logic                 out_valid_1,
    output logic                 out_valid_2,
    output rename_pkg::preg_t    out_dst_1,
    output rename_pkg::preg_t    out_dst_2,
    output rename_pkg::preg_t    out_src1_1,
    output rename_pkg::preg_t    out_src1_2,
    output rename_pkg::operand_t out_src2_1,
    output rename_pkg::operand_t out_src2_2,
    output rename_pkg::preg_t    ppreg_1,
    output rename_pkg::preg_t    ppreg_2,
    // commit port
    input  logic                 commit_valid,
    input  rename_pkg::lreg_t    commit_lreg,
    input  rename_pkg::preg_t    commit_preg
);

    logic fl_push;

    alloc_if alloc_bus ();
    map_if   map_bus ();

    // only registers of the renamed window go back to the pool
    assign fl_push = commit_valid && (commit_lreg >= `REN_LO) && (commit_lreg <= `REN_HI);

    // ------------------------------
    // state
    // ------------------------------
    free_list u_free_list (
        .clk       (clk),
        .rst_n     (rst_n),
        .pool      (alloc_bus.pool),
        .push      (fl_push),
        .push_preg (commit_preg)
    );

    rename_table u_rename_table (
        .clk   (clk),
        .rst_n (rst_n),
        .tbl   (map_bus.tbl)
    );

    // ------------------------------
    // datapath and control
    // ------------------------------
    rename_control u_rename_control (
        .in_valid_1  (in_valid_1),
        .in_valid_2  (in_valid_2),
        .dst_1       (dst_1),
        .dst_2       (dst_2),
        .src1_1      (src1_1),
        .src1_2      (src1_2),
        .src2_1      (src2_1),
        .src2_2      (src2_2),
        .is_imm_1    (is_imm_1),
        .is_imm_2    (is_imm_2),
        .out_ready   (out_ready),
        .out_valid_1 (out_valid_1),
        .out_valid_2 (out_valid_2),
        .in_ready    (in_ready),
        .out_dst_1   (out_dst_1),
        .out_dst_2   (out_dst_2),
        .out_src1_1  (out_src1_1),
        .out_src1_2  (out_src1_2),
        .out_src2_1  (out_src2_1),
        .out_src2_2  (out_src2_2),
        .ppreg_1     (ppreg_1),
        .ppreg_2     (ppreg_2),
        .alloc       (alloc_bus.ctrl),
        .map         (map_bus.ctrl)
    );

endmodule

//--- verification/reg_rename_sva.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

module reg_rename_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 in_valid_1,
    input logic                 in_valid_2,
    input logic                 in_ready,
    input logic                 out_ready,
    input logic                 out_valid_1,
    input logic                 out_valid_2,
    input rename_pkg::lreg_t    dst_1,
    input rename_pkg::lreg_t    dst_2,
    input rename_pkg::lreg_t    src1_1,
    input rename_pkg::lreg_t    src1_2,
    input rename_pkg::operand_t src2_1,
    input rename_pkg::operand_t src2_2,
    input logic                 is_imm_1,
    input logic                 is_imm_2,
    input rename_pkg::preg_t    out_dst_1,
    input rename_pkg::preg_t    out_dst_2
);
    import rename_pkg::*;

    int fail_count = 0;

    function automatic logic in_ren_window(input lreg_t r);
        return (r >= `REN_LO) && (r <= `REN_HI);
    endfunction

    // identity registers or the spare pool
    function automatic logic legal_preg(input preg_t p);
        return ((p >= `REN_LO) && (p <= `REN_HI)) ||
               ((p >= `FL_RESET_BASE) && (p < `FL_RESET_BASE + `FL_RESET_COUNT));
    endfunction

    // ------------------------------
    // input handshake
    // ------------------------------
    a_slot2_with_slot1: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid_2 |-> in_valid_1)
        else begin
            fail_count++;
            $error("in_valid_2 high without in_valid_1");
        end

    // acceptance needs both sides ready
    a_valid_implies_ready: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid_1 |-> (in_ready && out_ready))
        else begin
            fail_count++;
            $error("out_valid_1 high without in_ready and out_ready");
        end

    // stalled bundle must not move
    a_bundle_held: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid_1 && !in_ready) |=> $stable({in_valid_1, in_valid_2, dst_1, dst_2,
            src1_1, src1_2, src2_1, src2_2, is_imm_1, is_imm_2}))
        else begin
            fail_count++;
            $error("bundle changed while stalled");
        end

    // ------------------------------
    // renamed destinations
    // ------------------------------
    a_dst_range: assert property (@(posedge clk) disable iff (!rst_n)
        ((out_valid_1 && in_ren_window(dst_1)) |-> legal_preg(out_dst_1)) and
        ((out_valid_2 && in_ren_window(dst_2)) |-> legal_preg(out_dst_2)))
        else begin
            fail_count++;
            $error("renamed destination outside 8..15 and 32..39");
        end

endmodule

bind reg_rename reg_rename_sva i_sva (.*);

//--- verification/reg_rename_tb.sv
`timescale 1ns/1ps

`include "rename_defines.svh"

module reg_rename_tb;
    import rename_pkg::*;

    localparam int HALF    = 10;
    localparam int TIMEOUT = 20;

    // one bundle and its commit in drive_inputs field order
    typedef struct packed {
        logic     v1;
        lreg_t    d1, s1_1;
        operand_t s2_1;
        logic     imm1, v2;
        lreg_t    d2, s1_2;
        operand_t s2_2;
        logic     imm2, ordy, cv;
        lreg_t    clreg;
        preg_t    cpreg;
        logic     exp;
    } row_t;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     in_valid_1, in_valid_2, is_imm_1, is_imm_2, out_ready, commit_valid;
    logic     in_ready, out_valid_1, out_valid_2;
    lreg_t    dst_1, dst_2, src1_1, src1_2, commit_lreg;
    operand_t src2_1, src2_2, out_src2_1, out_src2_2;
    preg_t    out_dst_1, out_dst_2, out_src1_1, out_src1_2, ppreg_1, ppreg_2;
    preg_t    commit_preg;

    // reference model
    preg_t    model_map [`MAP_ENTRIES];
    preg_t    free_q [$];
    row_t     rows [$];

    reg_rename i_dut (.*);

    always #(HALF) clk = ~clk;

    function automatic logic is_renamed(input lreg_t r);
        return (r >= `REN_LO) && (r <= `REN_HI);
    endfunction

    function automatic preg_t map_src(input lreg_t r);
        return is_renamed(r) ? model_map[r - `REN_LO] : preg_t'(r);
    endfunction

    function automatic logic predict_fire(input row_t r);
        int need;
        need = int'(r.v1 && is_renamed(r.d1)) + int'(r.v2 && is_renamed(r.d2));
        return r.v1 && r.ordy && (free_q.size() >= need);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic drive_inputs(input row_t r);
        {in_valid_1, dst_1, src1_1, src2_1, is_imm_1, in_valid_2, dst_2, src1_2, src2_2,
         is_imm_2, out_ready, commit_valid, commit_lreg, commit_preg} = r[$bits(row_t)-1:1];
    endtask

    // ------------------------------
    // compare one accepted bundle and advance the model
    // ------------------------------
    task automatic accept_bundle(input row_t r);
        preg_t    e_dst_1;
        preg_t    e_dst_2;
        operand_t e_src2;
        int       idx;
        e_dst_1 = is_renamed(r.d1) ? free_q[0] : preg_t'(r.d1);
        idx     = int'(is_renamed(r.d1));
        e_dst_2 = (r.v2 && is_renamed(r.d2)) ? free_q[idx] : preg_t'(r.d2);
        check_value("out_dst_1", out_dst_1, e_dst_1);
        check_value("out_src1_1", out_src1_1, map_src(r.s1_1));
        e_src2 = r.s2_1;
        if (!r.imm1 && is_renamed(r.s2_1.lreg.num)) begin
            e_src2.preg = map_src(r.s2_1.lreg.num);
        end
        check_value("out_src2_1", out_src2_1, e_src2);
        if (is_renamed(r.d1)) begin
            check_value("ppreg_1", ppreg_1, map_src(r.d1));
        end
        if (r.v2) begin
            check_value("out_dst_2", out_dst_2, e_dst_2);
            check_value("out_src1_2", out_src1_2,
                        (r.s1_2 == r.d1) ? e_dst_1 : map_src(r.s1_2));
            e_src2 = r.s2_2;
            if (!r.imm2 && (r.s2_2.lreg.num == r.d1)) begin
                e_src2.preg = e_dst_1;
            end else if (!r.imm2 && is_renamed(r.s2_2.lreg.num)) begin
                e_src2.preg = map_src(r.s2_2.lreg.num);
            end
            check_value("out_src2_2", out_src2_2, e_src2);
            if (is_renamed(r.d2)) begin
                check_value("ppreg_2", ppreg_2,
                            (is_renamed(r.d1) && (r.d2 == r.d1)) ? e_dst_1 : map_src(r.d2));
            end
        end
        // slot 2 written last as the younger instruction
        if (is_renamed(r.d1)) begin
            model_map[r.d1 - `REN_LO] = free_q.pop_front();
        end
        if (r.v2 && is_renamed(r.d2)) begin
            model_map[r.d2 - `REN_LO] = free_q.pop_front();
        end
    endtask

    // bundle held until accepted with the commit in the first cycle only
    task automatic run_row(input row_t r);
        int   cycles;
        logic fired;
        logic done;
        cycles = 0;
        fired  = 1'b0;
        done   = 1'b0;
        drive_inputs(r);
        while (!done) begin
            #(HALF / 2);
            fired = predict_fire(r);
            check_value("out_valid_1", out_valid_1, fired);
            check_value("out_valid_2", out_valid_2, fired && r.v2);
            check_value("in_ready", in_ready, fired);
            if (fired) begin
                accept_bundle(r);
            end
            if ((cycles == 0) && r.cv && is_renamed(r.clreg)) begin
                free_q.push_back(r.cpreg);
            end
            @(negedge clk);
            commit_valid = 1'b0;
            cycles++;
            if (fired || !r.exp) begin
                done = 1'b1;
            end else if (cycles >= TIMEOUT) begin
                $display("timeout: bundle not accepted within %0d cycles", TIMEOUT);
                $display("=== FAIL ===");
                $fatal(1, "handshake timeout");
            end
        end
        check_value("out_valid_1 outcome", fired, r.exp);
    endtask

    task automatic load_table();
        // v1 d1 s1 s2 imm | v2 d2 s1 s2 imm | ordy | cv lreg preg | exp
        // reset map and pass-through
        rows.push_back(row_t'{1, 3, 9, 14, 0, 1, 20, 8, 2, 0, 1, 0, 0, 0, 1});
        // allocation in queue order
        rows.push_back(row_t'{1, 8, 10, 11, 0, 1, 9, 12, 1, 0, 1, 0, 0, 0, 1});
        rows.push_back(row_t'{1, 10, 8, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1});
        // slot 2 reads slot 1 result and shares its destination
        rows.push_back(row_t'{1, 11, 9, 0, 0, 1, 12, 11, 11, 0, 1, 0, 0, 0, 1});
        rows.push_back(row_t'{1, 13, 1, 0, 0, 1, 13, 13, 3, 0, 1, 0, 0, 0, 1});
        // immediates on renamed numbers
        rows.push_back(row_t'{1, 2, 12, 10, 1, 1, 4, 2, 9, 1, 1, 0, 0, 0, 1});
        // back-pressure and then the same bundle goes through
        rows.push_back(row_t'{1, 14, 13, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0});
        rows.push_back(row_t'{1, 14, 13, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 1});
        // commit releases the stall on an empty pool
        rows.push_back(row_t'{1, 15, 14, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0});
        rows.push_back(row_t'{1, 15, 14, 0, 0, 0, 0, 0, 0, 0, 1, 1, 8, 8, 1});
        // commit outside the window is dropped
        rows.push_back(row_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 3, 50, 0});
        // recycled registers leave in commit order
        rows.push_back(row_t'{0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 9, 9, 0});
        rows.push_back(row_t'{1, 8, 0, 0, 0, 1, 9, 0, 0, 0, 1, 1, 10, 10, 1});
        rows.push_back(row_t'{1, 12, 0, 0, 0, 0, 0, 0, 0, 0, 1, 0, 0, 0, 0});
        rows.push_back(row_t'{1, 12, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 11, 11, 1});
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        drive_inputs('0);
        rst_n = 1'b0;
        load_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < `MAP_ENTRIES; i++) begin
            model_map[i] = preg_t'(`REN_LO + i);
        end
        for (int i = 0; i < `FL_RESET_COUNT; i++) begin
            free_q.push_back(preg_t'(`FL_RESET_BASE + i));
        end
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        drive_inputs('0);
        repeat (2) @(negedge clk);
        if (i_dut.i_sva.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("concurrent assertions failed %0d times", i_dut.i_sva.fail_count);
            $display("=== FAIL ===");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

//--- reg_rename.f
+incdir+src
src/rename_pkg.sv
src/alloc_if.sv
src/map_if.sv
src/free_list.sv
src/rename_table.sv
src/rename_control.sv
src/reg_rename.sv
verification/reg_rename_sva.sv
verification/reg_rename_tb.sv
